/* design/ccx_bus_router.sv */
// ------------------------------
// Bus router. Steers accesses to
// RAM or timer and merges replies.
// ------------------------------
module ccx_bus_router (
    input logic    f_clk,
    input logic    g_resetn,
    ccx_memif.RSP  up,
    ccx_memif.REQ  ram,
    ccx_memif.REQ  mmio
);
    import ccx_pkg::*;

    bus_target_e tgt;       // Owner of the current request.
    bus_target_e rsp_tgt;   // Owner of last cycle's accepted access.
    logic        sel_gnt;
    logic        acc;
    logic        unmapped_q;

    // Address decode against the two windows.
    always_comb begin
        if ((up.addr - RAM_BASE_ADDR) < RAM_WORDS * 4) begin
            tgt = TGT_RAM;
        end else if ((up.addr - MMIO_BASE_ADDR) < MMIO_SIZE) begin
            tgt = TGT_MMIO;
        end else begin
            tgt = TGT_NONE;
        end
    end

    // Request goes straight through to its owner.
    assign ram.req    = up.req && (tgt == TGT_RAM);
    assign ram.wen    = up.wen;
    assign ram.addr   = up.addr;
    assign ram.wdata  = up.wdata;

    assign mmio.req   = up.req && (tgt == TGT_MMIO);
    assign mmio.wen   = up.wen;
    assign mmio.addr  = up.addr;
    assign mmio.wdata = up.wdata;

    always_comb begin
        case (tgt)
            TGT_RAM:  sel_gnt = ram.gnt;
            TGT_MMIO: sel_gnt = mmio.gnt;
            default:  sel_gnt = 1'b1;    // Unmapped, take it and fault.
        endcase
    end

    assign up.gnt = g_resetn && sel_gnt; // Nothing accepted in reset.
    assign acc    = up.req && up.gnt;

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            rsp_tgt    <= TGT_NONE;
            unmapped_q <= 1'b0;
        end else begin
            rsp_tgt    <= acc ? tgt : TGT_NONE;
            unmapped_q <= acc && (tgt == TGT_NONE);
        end
    end

    // Response from whoever took the access.
    always_comb begin
        case (rsp_tgt)
            TGT_RAM: begin
                up.rdata = ram.rdata;
                up.error = ram.error;
            end
            TGT_MMIO: begin
                up.rdata = mmio.rdata;
                up.error = mmio.error;
            end
            default: begin
                up.rdata = '0;
                up.error = unmapped_q;
            end
        endcase
    end

    a_one_target: assert property (@(posedge f_clk) disable iff (!g_resetn)
        !(ram.req && mmio.req));

    // Unmapped access faults in the following cycle only.
    a_unmapped_err: assert property (@(posedge f_clk) disable iff (!g_resetn)
        (acc && tgt == TGT_NONE) |=> (up.error && up.rdata == '0));

endmodule

/* design/ccx_memif.sv */
// ------------------------------
// Request/grant memory bus with
// a one cycle response phase.
// ------------------------------
interface ccx_memif;

    // Request phase.
    logic        req;
    logic        gnt;
    logic        wen;     // Write when high.
    logic [31:0] addr;    // Byte address, word aligned.
    logic [31:0] wdata;

    // Response phase, the cycle after accept.
    logic [31:0] rdata;
    logic        error;

    modport REQ (
        output req, wen, addr, wdata,
        input  gnt, rdata, error
    );

    modport RSP (
        input  req, wen, addr, wdata,
        output gnt, rdata, error
    );

endinterface

/* design/ccx_mmio.sv */
// ------------------------------
// Timer registers, timer IRQ and
// cycle/instret counters.
// ------------------------------
module ccx_mmio (
    input  logic        f_clk,
    input  logic        g_resetn,
    input  logic        instr_ret,       // Instruction retired this cycle.
    input  logic        inhibit_cy,
    input  logic        inhibit_ir,
    ccx_memif.RSP       bus,
    output logic        timer_interrupt,
    output logic [63:0] ctr_time,
    output logic [63:0] ctr_cycle,
    output logic [63:0] ctr_instret
);
    import ccx_pkg::*;

    logic [31:0] off;
    mmio_reg_e   sel;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [31:0] rd_word;
    logic        wr_mtime_lo;
    logic        wr_mtime_hi;
    logic        wr_cmp_lo;
    logic        wr_cmp_hi;

    assign bus.gnt = 1'b1; // Never stalls.

    // Only the offset inside the window matters here.
    assign off = bus.addr & (MMIO_SIZE - 32'd1);

    always_comb begin
        case (off)
            MTIME_LO_OFF:    sel = REG_MTIME_LO;
            MTIME_HI_OFF:    sel = REG_MTIME_HI;
            MTIMECMP_LO_OFF: sel = REG_MTIMECMP_LO;
            MTIMECMP_HI_OFF: sel = REG_MTIMECMP_HI;
            default:         sel = REG_NONE;
        endcase
    end

    assign wr_mtime_lo = bus.req && bus.wen && (sel == REG_MTIME_LO);
    assign wr_mtime_hi = bus.req && bus.wen && (sel == REG_MTIME_HI);
    assign wr_cmp_lo   = bus.req && bus.wen && (sel == REG_MTIMECMP_LO);
    assign wr_cmp_hi   = bus.req && bus.wen && (sel == REG_MTIMECMP_HI);

    // A write to either half stalls the count for that edge.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            mtime <= '0;
        end else if (wr_mtime_hi) begin
            mtime <= {bus.wdata, mtime[31:0]};
        end else if (wr_mtime_lo) begin
            mtime <= {mtime[63:32], bus.wdata};
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            mtimecmp <= MTIMECMP_RESET;
        end else if (wr_cmp_hi) begin
            mtimecmp <= {bus.wdata, mtimecmp[31:0]};
        end else if (wr_cmp_lo) begin
            mtimecmp <= {mtimecmp[63:32], bus.wdata};
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            timer_interrupt <= 1'b0;
        end else begin
            timer_interrupt <= (mtime >= mtimecmp);
        end
    end

    always_comb begin
        case (sel)
            REG_MTIME_LO:    rd_word = mtime[31:0];
            REG_MTIME_HI:    rd_word = mtime[63:32];
            REG_MTIMECMP_LO: rd_word = mtimecmp[31:0];
            REG_MTIMECMP_HI: rd_word = mtimecmp[63:32];
            default:         rd_word = '0;
        endcase
    end

    // Hole in the window faults, reads and writes alike.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            bus.error <= 1'b0;
        end else begin
            bus.error <= bus.req && (sel == REG_NONE);
        end
    end

    always_ff @(posedge f_clk) begin
        if (bus.req) begin
            bus.rdata <= rd_word;
        end
    end

    assign ctr_time = mtime;

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            ctr_cycle <= '0;
        end else if (!inhibit_cy) begin
            ctr_cycle <= ctr_cycle + 64'd1;
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            ctr_instret <= '0;
        end else if (instr_ret && !inhibit_ir) begin
            ctr_instret <= ctr_instret + 64'd1;
        end
    end

    // Depends on mtimecmp coming out of reset at its maximum.
    a_irq_after_reset: assert property (@(posedge f_clk)
        $rose(g_resetn) |=> !timer_interrupt);

endmodule

/* design/ccx_pkg.sv */
// ------------------------------
// Core complex memory map, reset
// values and select encodings.
// ------------------------------
package ccx_pkg;

    // Scratch RAM window.
    localparam logic [31:0] RAM_BASE_ADDR = 32'h0000_0000;
    localparam int          RAM_WORDS     = 256;            // 1 KiB of words.
    localparam int          RAM_IDX_W     = $clog2(RAM_WORDS);

    // Timer register window.
    localparam logic [31:0] MMIO_BASE_ADDR = 32'h0000_1000;
    localparam logic [31:0] MMIO_SIZE      = 32'h0000_0100;

    // Register byte offsets inside the timer window.
    localparam logic [31:0] MTIME_LO_OFF    = 32'd0;
    localparam logic [31:0] MTIME_HI_OFF    = 32'd4;
    localparam logic [31:0] MTIMECMP_LO_OFF = 32'd8;
    localparam logic [31:0] MTIMECMP_HI_OFF = 32'd12;

    localparam logic [63:0] MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF; // Never fires.

    // Owner of an accepted access.
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_MMIO
    } bus_target_e;

    // Decoded timer register.
    typedef enum logic [2:0] {
        REG_MTIME_LO,
        REG_MTIME_HI,
        REG_MTIMECMP_LO,
        REG_MTIMECMP_HI,
        REG_NONE
    } mmio_reg_e;

endpackage

/* design/ccx_sram.sv */
// ------------------------------
// Scratch RAM responder, whole
// word accesses only.
// ------------------------------
module ccx_sram (
    input logic    f_clk,
    input logic    g_resetn,
    ccx_memif.RSP  bus
);
    import ccx_pkg::*;

    logic [31:0]          mem [RAM_WORDS];
    logic [31:0]          win_off;     // Byte offset inside the window.
    logic [RAM_IDX_W-1:0] idx;
    logic                 ram_wr;

    assign bus.gnt   = 1'b1;
    assign bus.error = 1'b0;

    assign win_off = bus.addr - RAM_BASE_ADDR;
    assign idx     = win_off[RAM_IDX_W+1:2];
    assign ram_wr  = bus.req && bus.wen;

    always_ff @(posedge f_clk) begin
        if (g_resetn && ram_wr) begin // Writes held in reset are dropped.
            mem[idx] <= bus.wdata;
        end
    end

    // Read data for the next cycle.
    always_ff @(posedge f_clk) begin
        if (bus.req && !bus.wen) begin
            bus.rdata <= mem[idx];
        end
    end

    // Router decode must keep requests inside the array.
    a_idx_range: assert property (@(posedge f_clk) disable iff (!g_resetn)
        bus.req |-> ((win_off >> 2) < RAM_WORDS));

endmodule

/* design/ccx_top.sv */
// ------------------------------
// Core complex memory subsystem,
// router with RAM and timer.
// ------------------------------
module ccx_top (
    input  logic        f_clk,
    input  logic        g_resetn,
    input  logic        mem_req,
    input  logic        mem_wen,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic        instr_ret,
    input  logic        inhibit_cy,
    input  logic        inhibit_ir,
    output logic        mem_gnt,
    output logic [31:0] mem_rdata,
    output logic        mem_error,
    output logic        timer_interrupt,
    output logic [63:0] ctr_time,
    output logic [63:0] ctr_cycle,
    output logic [63:0] ctr_instret
);

    ccx_memif bus_up ();
    ccx_memif bus_ram ();
    ccx_memif bus_mmio ();

    // Requester side onto the bus.
    assign bus_up.req   = mem_req;
    assign bus_up.wen   = mem_wen;
    assign bus_up.addr  = mem_addr;
    assign bus_up.wdata = mem_wdata;

    assign mem_gnt   = bus_up.gnt;
    assign mem_rdata = bus_up.rdata;
    assign mem_error = bus_up.error;

    ccx_bus_router u_router (
        .f_clk    (f_clk),
        .g_resetn (g_resetn),
        .up       (bus_up.RSP),
        .ram      (bus_ram.REQ),
        .mmio     (bus_mmio.REQ)
    );

    ccx_sram u_sram (
        .f_clk    (f_clk),
        .g_resetn (g_resetn),
        .bus      (bus_ram.RSP)
    );

    ccx_mmio u_mmio (
        .f_clk           (f_clk),
        .g_resetn        (g_resetn),
        .instr_ret       (instr_ret),
        .inhibit_cy      (inhibit_cy),
        .inhibit_ir      (inhibit_ir),
        .bus             (bus_mmio.RSP),
        .timer_interrupt (timer_interrupt),
        .ctr_time        (ctr_time),
        .ctr_cycle       (ctr_cycle),
        .ctr_instret     (ctr_instret)
    );

endmodule

/* flist.f */
design/ccx_pkg.sv
design/ccx_memif.sv
design/ccx_bus_router.sv
design/ccx_sram.sv
design/ccx_mmio.sv
design/ccx_top.sv
testbench/tb_ccx_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_ccx_top -o tb_ccx_top

out=$(./obj_dir/tb_ccx_top)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

/* testbench/tb_ccx_top.sv */
// ------------------------------
// Testbench for the core complex
// memory subsystem.
// ------------------------------
module tb_ccx_top;
    import ccx_pkg::*;

    localparam int N_RAM     = 32;     // Random RAM writes.
    localparam int N_CTR     = 150;    // Cycles of counter stimulus.
    localparam int IRQ_WATCH = 70;
    localparam int B2B_LEN   = 8;
    // A few cycles per access plus the fixed-length loops, with margin.
    localparam int WDOG_CYCLES = 12 * (2 * N_RAM + 20) + N_CTR + IRQ_WATCH + B2B_LEN + 500;

    logic        f_clk;
    logic        g_resetn;
    logic        mem_req;
    logic        mem_wen;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        instr_ret;
    logic        inhibit_cy;
    logic        inhibit_ir;
    logic        mem_gnt;
    logic [31:0] mem_rdata;
    logic        mem_error;
    logic        timer_interrupt;
    logic [63:0] ctr_time;
    logic [63:0] ctr_cycle;
    logic [63:0] ctr_instret;

    int          cyc = 0;      // Rising edges seen so far.
    int          err_cnt = 0;
    int          n_tests = 0;
    int          test_errs;
    logic [31:0] rng = 32'h2374_2835;
    logic [63:0] time_at_acc;  // ctr_time in the cycle ending at the accept edge.
    logic [31:0] ram_model [RAM_WORDS];
    int          written [$];

    ccx_top ccx_top_inst (.*);

    initial begin
        f_clk = 1'b0;
        forever #2 f_clk = ~f_clk;
    end

    always @(posedge f_clk) cyc <= cyc + 1;

    function automatic void log_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        err_cnt++;
    endfunction

    function automatic void note_problem(input string msg);
        $display("Problem at time %0t: %s", $time, msg);
        err_cnt++;
    endfunction

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic logic [31:0] ram_addr(input int idx);
        return RAM_BASE_ADDR + 32'(idx) * 32'd4;
    endfunction

    task automatic begin_test();
        test_errs = err_cnt;
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        $display("Test %s finished with %0d error(s)", name, err_cnt - test_errs);
    endtask

    task automatic drive_req(input logic wr, input logic [31:0] a, input logic [31:0] d);
        mem_req   <= 1'b1;
        mem_wen   <= wr;
        mem_addr  <= a;
        mem_wdata <= d;
    endtask

    // One access; returns the response and the index of its accept edge.
    task automatic bus_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                              output logic [31:0] rd, output logic err, output int acc_edge);
        int   waited;
        logic granted;
        waited = 0;
        @(posedge f_clk);
        drive_req(wr, a, d);
        do begin
            @(negedge f_clk);
            granted     = mem_gnt;
            acc_edge    = cyc + 1;
            time_at_acc = ctr_time;
            waited++;
            @(posedge f_clk);
        end while (!granted && waited < 16);
        mem_req <= 1'b0;
        @(negedge f_clk);
        rd  = mem_rdata;
        err = mem_error;
        assert (granted) else note_problem($sformatf("no grant for address %h", a));
    endtask

    task automatic test_ram();
        int          idx;
        int          e;
        logic [31:0] d;
        logic [31:0] rd;
        logic        err;
        begin_test();
        repeat (N_RAM) begin
            idx = int'(next_rand() % 32'(RAM_WORDS));
            d   = next_rand();
            bus_access(1'b1, ram_addr(idx), d, rd, err, e);
            assert (!err) else log_mismatch($sformatf("error on RAM write to word %0d", idx));
            ram_model[idx] = d;
            written.push_back(idx);
        end
        foreach (written[i]) begin
            bus_access(1'b0, ram_addr(written[i]), '0, rd, err, e);
            assert (rd == ram_model[written[i]] && !err)
                else log_mismatch($sformatf("RAM word %0d read %h err %b, expected %h",
                                            written[i], rd, err, ram_model[written[i]]));
        end
        finish_test("ram");
    endtask

    task automatic test_mtime();
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] lo_at_hi;
        logic [31:0] rd;
        logic [63:0] expected;
        logic        err;
        int          e_lo;
        int          e_hi;
        int          e_rd;
        begin_test();
        v = next_rand();
        w = next_rand();
        bus_access(1'b1, MMIO_BASE_ADDR + MTIME_LO_OFF, v, rd, err, e_lo);
        repeat (next_rand() % 32'd4) @(posedge f_clk);
        bus_access(1'b1, MMIO_BASE_ADDR + MTIME_HI_OFF, w, rd, err, e_hi);
        repeat (next_rand() % 32'd4) @(posedge f_clk);
        bus_access(1'b0, MMIO_BASE_ADDR + MTIME_LO_OFF, '0, rd, err, e_rd);
        // Low half counts between the writes, then holds on the high-half write edge.
        lo_at_hi = v + 32'(e_hi - e_lo - 1);
        expected = {w, lo_at_hi} + 64'(e_rd - e_hi - 1);
        assert (rd == expected[31:0] && !err)
            else log_mismatch($sformatf("mtime low read %h, expected %h", rd, expected[31:0]));
        assert (time_at_acc == expected)
            else log_mismatch($sformatf("ctr_time %h, expected %h", time_at_acc, expected));
        finish_test("mtime");
    endtask

    task automatic test_timer_irq();
        logic [31:0] rd;
        logic [31:0] c;
        logic        err;
        int          e;
        int          z;
        begin_test();
        assert (!timer_interrupt) else log_mismatch("timer_interrupt high after reset");
        bus_access(1'b0, MMIO_BASE_ADDR + MTIMECMP_LO_OFF, '0, rd, err, e);
        assert (rd == MTIMECMP_RESET[31:0]) else log_mismatch("mtimecmp low not reset");
        bus_access(1'b0, MMIO_BASE_ADDR + MTIMECMP_HI_OFF, '0, rd, err, e);
        assert (rd == MTIMECMP_RESET[63:32]) else log_mismatch("mtimecmp high not reset");
        bus_access(1'b1, MMIO_BASE_ADDR + MTIME_LO_OFF, '0, rd, err, z);
        bus_access(1'b1, MMIO_BASE_ADDR + MTIME_HI_OFF, '0, rd, err, e);
        z = z + 1;                          // High-half write edge skips one count.
        c = 32'd36 + (next_rand() % 32'd8);
        bus_access(1'b1, MMIO_BASE_ADDR + MTIMECMP_HI_OFF, '0, rd, err, e);
        bus_access(1'b1, MMIO_BASE_ADDR + MTIMECMP_LO_OFF, c, rd, err, e);
        repeat (IRQ_WATCH) begin
            @(negedge f_clk);
            // Flag follows the compare made before the last edge.
            assert (timer_interrupt == ((cyc - 1 - z) >= int'(c)))
                else log_mismatch($sformatf("timer_interrupt %b with mtime %0d, cmp %0d",
                                            timer_interrupt, cyc - z, c));
        end
        bus_access(1'b1, MMIO_BASE_ADDR + MTIMECMP_HI_OFF, 32'hFFFF_FFFF, rd, err, e);
        assert (timer_interrupt) else log_mismatch("timer_interrupt dropped too early");
        @(negedge f_clk);
        assert (!timer_interrupt) else log_mismatch("timer_interrupt not cleared");
        bus_access(1'b1, MMIO_BASE_ADDR + MTIMECMP_LO_OFF, 32'hFFFF_FFFF, rd, err, e);
        finish_test("timer_irq");
    endtask

    task automatic test_counters();
        logic [63:0] exp_cy;
        logic [63:0] exp_ir;
        logic [31:0] r;
        logic        cur_cy;
        logic        cur_ir;
        logic        cur_ret;
        begin_test();
        @(negedge f_clk);
        exp_cy  = ctr_cycle;
        exp_ir  = ctr_instret;
        cur_cy  = 1'b0;
        cur_ir  = 1'b0;
        cur_ret = 1'b0;
        repeat (N_CTR) begin
            @(posedge f_clk);
            if (!cur_cy) exp_cy = exp_cy + 64'd1;
            if (cur_ret && !cur_ir) exp_ir = exp_ir + 64'd1;
            r       = next_rand();
            cur_cy  = r[0] & r[1];
            cur_ir  = r[2] & r[3];
            cur_ret = r[4];
            inhibit_cy <= cur_cy;
            inhibit_ir <= cur_ir;
            instr_ret  <= cur_ret;
            @(negedge f_clk);
            assert (ctr_cycle == exp_cy)
                else log_mismatch($sformatf("ctr_cycle %0d, expected %0d", ctr_cycle, exp_cy));
            assert (ctr_instret == exp_ir)
                else log_mismatch($sformatf("ctr_instret %0d, expected %0d",
                                            ctr_instret, exp_ir));
        end
        @(posedge f_clk);
        inhibit_cy <= 1'b0;
        inhibit_ir <= 1'b0;
        instr_ret  <= 1'b0;
        finish_test("counters");
    endtask

    task automatic test_errors_b2b();
        logic [31:0] rd;
        logic [31:0] b2b_addr [B2B_LEN];
        logic [31:0] b2b_exp [B2B_LEN];
        logic        err;
        int          e;
        begin_test();
        bus_access(1'b0, 32'h0000_8000, '0, rd, err, e);
        assert (err && rd == '0) else log_mismatch("unmapped read gave no error");
        bus_access(1'b0, MMIO_BASE_ADDR + 32'd16, '0, rd, err, e);
        assert (err) else log_mismatch("read of MMIO offset 16 gave no error");
        for (int i = 0; i < B2B_LEN; i++) begin
            if (i % 2 == 0) begin
                b2b_addr[i] = ram_addr(written[i]);
                b2b_exp[i]  = ram_model[written[i]];
            end else if (i % 4 == 1) begin
                b2b_addr[i] = MMIO_BASE_ADDR + MTIMECMP_LO_OFF;
                b2b_exp[i]  = 32'hFFFF_FFFF;
            end else begin
                b2b_addr[i] = MMIO_BASE_ADDR + MTIME_HI_OFF;  // Still zero after the IRQ test.
                b2b_exp[i]  = 32'h0;
            end
        end
        @(posedge f_clk);
        drive_req(1'b0, b2b_addr[0], '0);
        for (int i = 0; i < B2B_LEN; i++) begin
            @(posedge f_clk);   // Accept edge of access i.
            if (i + 1 < B2B_LEN) drive_req(1'b0, b2b_addr[i + 1], '0);
            else mem_req <= 1'b0;
            @(negedge f_clk);
            assert (mem_rdata == b2b_exp[i] && !mem_error)
                else log_mismatch($sformatf("back to back read %0d at %h gave %h, expected %h",
                                            i, b2b_addr[i], mem_rdata, b2b_exp[i]));
        end
        finish_test("errors_b2b");
    endtask

    a_gnt_in_reset: assert property (@(posedge f_clk) !g_resetn |-> !mem_gnt)
        else note_problem("grant was high during reset");
    a_gnt_always: assert property (@(posedge f_clk) g_resetn |-> mem_gnt)
        else note_problem("grant dropped while out of reset");
    a_reset_values: assert property (@(posedge f_clk) $rose(g_resetn) |->
        (!mem_error && !timer_interrupt && ctr_cycle == '0 && ctr_instret == '0
         && ctr_time == '0))
        else note_problem("outputs not cleared by reset");

    // Watchdog.
    initial begin
        repeat (WDOG_CYCLES) @(posedge f_clk);
        $display("Timeout: the tests did not finish within %0d cycles", WDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        g_resetn   <= 1'b0;
        mem_req    <= 1'b0;
        mem_wen    <= 1'b0;
        mem_addr   <= '0;
        mem_wdata  <= '0;
        instr_ret  <= 1'b0;
        inhibit_cy <= 1'b0;
        inhibit_ir <= 1'b0;
        repeat (5) @(posedge f_clk);
        g_resetn <= 1'b1;
        test_ram();
        test_mtime();
        test_timer_irq();
        test_counters();
        test_errors_b2b();
        $display("Summary: %0d tests run, %0d errors", n_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
